//--- ex_pkg.sv
// execute stage shared definitions: instruction codes, widths and memory access codes
package ex_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    // register 0 means no write-back
    typedef logic [4:0]        reg_addr_t;
    typedef logic [15:0]       imm_t;
    typedef logic [4:0]        shamt_t;
    typedef logic [7:0]        inst_code_t;
    typedef logic [1:0]        mem_type_t;
    typedef logic [2:0]        mem_size_t;
    // 0 to 32
    typedef logic [5:0]        lead_cnt_t;

    localparam inst_code_t INST_NOP   = 8'h00;

    // add, subtract, compare
    localparam inst_code_t INST_ADD   = 8'h01;
    localparam inst_code_t INST_ADDU  = 8'h02;
    localparam inst_code_t INST_SUB   = 8'h03;
    localparam inst_code_t INST_SUBU  = 8'h04;
    localparam inst_code_t INST_ADDI  = 8'h05;
    localparam inst_code_t INST_ADDIU = 8'h06;
    localparam inst_code_t INST_SLT   = 8'h07;
    localparam inst_code_t INST_SLTU  = 8'h08;
    localparam inst_code_t INST_SLTI  = 8'h09;
    localparam inst_code_t INST_SLTIU = 8'h0a;

    // logic and lui
    localparam inst_code_t INST_AND   = 8'h10;
    localparam inst_code_t INST_ANDI  = 8'h11;
    localparam inst_code_t INST_OR    = 8'h12;
    localparam inst_code_t INST_ORI   = 8'h13;
    localparam inst_code_t INST_XOR   = 8'h14;
    localparam inst_code_t INST_XORI  = 8'h15;
    localparam inst_code_t INST_NOR   = 8'h16;
    localparam inst_code_t INST_LUI   = 8'h17;

    // shifts
    localparam inst_code_t INST_SLL   = 8'h20;
    localparam inst_code_t INST_SLLV  = 8'h21;
    localparam inst_code_t INST_SRL   = 8'h22;
    localparam inst_code_t INST_SRLV  = 8'h23;
    localparam inst_code_t INST_SRA   = 8'h24;
    localparam inst_code_t INST_SRAV  = 8'h25;

    // leading count and conditional moves
    localparam inst_code_t INST_CLZ   = 8'h28;
    localparam inst_code_t INST_CLO   = 8'h29;
    localparam inst_code_t INST_MOVZ  = 8'h2a;
    localparam inst_code_t INST_MOVN  = 8'h2b;

    // loads and stores
    localparam inst_code_t INST_LB    = 8'h30;
    localparam inst_code_t INST_LBU   = 8'h31;
    localparam inst_code_t INST_LH    = 8'h32;
    localparam inst_code_t INST_LHU   = 8'h33;
    localparam inst_code_t INST_LW    = 8'h34;
    localparam inst_code_t INST_SB    = 8'h38;
    localparam inst_code_t INST_SH    = 8'h39;
    localparam inst_code_t INST_SW    = 8'h3a;

    localparam mem_type_t MEM_TYPE_R2R  = 2'd0;
    localparam mem_type_t MEM_TYPE_M2R  = 2'd1;
    localparam mem_type_t MEM_TYPE_R2M  = 2'd2;

    localparam mem_size_t MEM_SIZE_BYTE = 3'd0;
    localparam mem_size_t MEM_SIZE_HALF = 3'd1;
    localparam mem_size_t MEM_SIZE_WORD = 3'd2;

endpackage

//--- ex_operand_if.sv
// decoded instruction and operand bundle from the execute top to its units
`timescale 1ns/1ps

interface ex_operand_if;

    ex_pkg::inst_code_t inst;
    ex_pkg::word_t      rs_val;
    ex_pkg::word_t      rt_val;
    ex_pkg::imm_t       imm;
    ex_pkg::shamt_t     shamt;

    // driving side
    modport src (
        output inst, rs_val, rt_val, imm, shamt
    );

    // computing units, read only
    modport unit (
        input inst, rs_val, rt_val, imm, shamt
    );

endinterface

//--- ex_alu.sv
// execute ALU: add, subtract, set-less-than, logic and LUI with overflow detection
`timescale 1ns/1ps

module ex_alu (
    ex_operand_if.unit    opd,
    output ex_pkg::word_t alu_result_o,
    output logic          alu_ovf_o
);

    ex_pkg::word_t sign_ext_imm;
    ex_pkg::word_t zero_ext_imm;
    ex_pkg::word_t op_a;
    ex_pkg::word_t op_b;
    ex_pkg::word_t op_b_mux;
    ex_pkg::word_t sum;
    logic          use_imm;
    logic          signed_cmp;
    logic          negate;
    logic          sum_ovf;
    logic          less_than;

    assign sign_ext_imm = {{16{opd.imm[15]}}, opd.imm};
    assign zero_ext_imm = {16'h0000, opd.imm};

    assign use_imm = (opd.inst == ex_pkg::INST_ADDI) || (opd.inst == ex_pkg::INST_ADDIU) ||
                     (opd.inst == ex_pkg::INST_SLTI) || (opd.inst == ex_pkg::INST_SLTIU);
    assign signed_cmp = (opd.inst == ex_pkg::INST_SLT) || (opd.inst == ex_pkg::INST_SLTI);
    assign negate = (opd.inst == ex_pkg::INST_SUB) || (opd.inst == ex_pkg::INST_SUBU) ||
                    signed_cmp;

    assign op_a     = opd.rs_val;
    assign op_b     = use_imm ? sign_ext_imm : opd.rt_val;
    // two's complement negate for subtract and signed compare
    assign op_b_mux = negate ? (~op_b + 1'b1) : op_b;
    assign sum      = op_a + op_b_mux;

    // overflow judged on the true operand signs, so rs - 0x80000000 is caught too
    assign sum_ovf = negate ? ((op_a[31] != op_b[31]) && (sum[31] != op_a[31])) :
                              ((op_a[31] == op_b[31]) && (sum[31] != op_a[31]));

    // signed: differing signs decide directly, equal signs use the difference
    assign less_than = signed_cmp ?
                       ((op_a[31] & ~op_b[31]) | (~(op_a[31] ^ op_b[31]) & sum[31])) :
                       (op_a < op_b);

    always_comb
    begin
        alu_result_o = '0;
        case (opd.inst)
            ex_pkg::INST_ADD, ex_pkg::INST_ADDU, ex_pkg::INST_SUB, ex_pkg::INST_SUBU,
            ex_pkg::INST_ADDI, ex_pkg::INST_ADDIU:
                alu_result_o = sum;
            ex_pkg::INST_SLT, ex_pkg::INST_SLTU, ex_pkg::INST_SLTI, ex_pkg::INST_SLTIU:
                alu_result_o = {31'h0, less_than};
            ex_pkg::INST_AND:  alu_result_o = opd.rs_val & opd.rt_val;
            ex_pkg::INST_ANDI: alu_result_o = opd.rs_val & zero_ext_imm;
            ex_pkg::INST_OR:   alu_result_o = opd.rs_val | opd.rt_val;
            ex_pkg::INST_ORI:  alu_result_o = opd.rs_val | zero_ext_imm;
            ex_pkg::INST_XOR:  alu_result_o = opd.rs_val ^ opd.rt_val;
            ex_pkg::INST_XORI: alu_result_o = opd.rs_val ^ zero_ext_imm;
            ex_pkg::INST_NOR:  alu_result_o = ~(opd.rs_val | opd.rt_val);
            ex_pkg::INST_LUI:  alu_result_o = {opd.imm, 16'h0000};
            default:           alu_result_o = '0;
        endcase
    end

    // only the trapping forms report overflow
    assign alu_ovf_o = sum_ovf && ((opd.inst == ex_pkg::INST_ADD) ||
                                   (opd.inst == ex_pkg::INST_SUB) ||
                                   (opd.inst == ex_pkg::INST_ADDI));

endmodule

//--- ex_shifter.sv
// execute shifter: logical and arithmetic shifts by a fixed or register amount
`timescale 1ns/1ps

module ex_shifter (
    ex_operand_if.unit    opd,
    output ex_pkg::word_t shift_result_o
);

    ex_pkg::shamt_t amount;
    logic           variable;

    assign variable = (opd.inst == ex_pkg::INST_SLLV) || (opd.inst == ex_pkg::INST_SRLV) ||
                      (opd.inst == ex_pkg::INST_SRAV);
    // variable forms take the low five bits of rs
    assign amount = variable ? opd.rs_val[4:0] : opd.shamt;

    always_comb
    begin
        case (opd.inst)
            ex_pkg::INST_SLL, ex_pkg::INST_SLLV:
                shift_result_o = opd.rt_val << amount;
            ex_pkg::INST_SRL, ex_pkg::INST_SRLV:
                shift_result_o = opd.rt_val >> amount;
            ex_pkg::INST_SRA, ex_pkg::INST_SRAV:
                // sign bit fills the vacated positions
                shift_result_o = ex_pkg::word_t'($signed(opd.rt_val) >>> amount);
            default:
                shift_result_o = '0;
        endcase
    end

endmodule

//--- ex_lead_count.sv
// leading zero and leading one counter for CLZ and CLO
`timescale 1ns/1ps

module ex_lead_count (
    ex_operand_if.unit    opd,
    output ex_pkg::word_t count_result_o
);

    ex_pkg::word_t     scan_val;
    ex_pkg::lead_cnt_t count;
    logic              is_clo;
    logic              is_count;

    assign is_clo   = (opd.inst == ex_pkg::INST_CLO);
    assign is_count = is_clo || (opd.inst == ex_pkg::INST_CLZ);
    // CLO counts zeros of the inverted word
    assign scan_val = is_clo ? ~opd.rs_val : opd.rs_val;

    // highest set bit wins, all zero gives 32
    always_comb
    begin
        count = 6'd32;
        for (int i = 0; i < ex_pkg::WORD_W; i++)
        begin
            if (scan_val[i])
                count = ex_pkg::lead_cnt_t'(31 - i);
        end
    end

    assign count_result_o = is_count ? {26'h0, count} : '0;

endmodule

//--- ex_mem_ctrl.sv
// load and store control: address, direction, size and sign for the memory stage
`timescale 1ns/1ps

module ex_mem_ctrl (
    ex_operand_if.unit        opd,
    output ex_pkg::word_t     mem_addr_o,
    output ex_pkg::mem_type_t mem_type_o,
    output ex_pkg::mem_size_t mem_size_o,
    output logic              mem_signed_o
);

    ex_pkg::word_t eff_addr;

    // base plus sign-extended offset
    assign eff_addr = opd.rs_val + {{16{opd.imm[15]}}, opd.imm};

    always_comb
    begin
        mem_addr_o   = '0;
        mem_type_o   = ex_pkg::MEM_TYPE_R2R;
        mem_size_o   = ex_pkg::MEM_SIZE_WORD;
        mem_signed_o = 1'b1;
        case (opd.inst)
            ex_pkg::INST_LB, ex_pkg::INST_LBU, ex_pkg::INST_LH, ex_pkg::INST_LHU,
            ex_pkg::INST_LW:
            begin
                mem_addr_o = eff_addr;
                mem_type_o = ex_pkg::MEM_TYPE_M2R;
            end
            ex_pkg::INST_SB, ex_pkg::INST_SH, ex_pkg::INST_SW:
            begin
                mem_addr_o = eff_addr;
                mem_type_o = ex_pkg::MEM_TYPE_R2M;
            end
            default:
                mem_addr_o = '0;
        endcase

        // access width
        case (opd.inst)
            ex_pkg::INST_LB, ex_pkg::INST_LBU, ex_pkg::INST_SB:
                mem_size_o = ex_pkg::MEM_SIZE_BYTE;
            ex_pkg::INST_LH, ex_pkg::INST_LHU, ex_pkg::INST_SH:
                mem_size_o = ex_pkg::MEM_SIZE_HALF;
            default:
                mem_size_o = ex_pkg::MEM_SIZE_WORD;
        endcase

        // only the unsigned loads skip sign extension
        if ((opd.inst == ex_pkg::INST_LBU) || (opd.inst == ex_pkg::INST_LHU))
            mem_signed_o = 1'b0;
    end

endmodule

//--- ex_result_stage.sv
// execute result stage: merges unit results, picks the destination and registers outputs
`timescale 1ns/1ps

module ex_result_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_i,
    ex_operand_if.unit               opd,
    input  ex_pkg::reg_addr_t        rt_i,
    input  ex_pkg::reg_addr_t        rd_i,
    input  ex_pkg::word_t            alu_result_i,
    input  logic                     alu_ovf_i,
    input  ex_pkg::word_t            shift_result_i,
    input  ex_pkg::word_t            count_result_i,
    input  ex_pkg::word_t            mem_addr_i,
    input  ex_pkg::mem_type_t        mem_type_i,
    input  ex_pkg::mem_size_t        mem_size_i,
    input  logic                     mem_signed_i,
    output logic                     valid_o,
    output ex_pkg::word_t            result_o,
    output ex_pkg::reg_addr_t        dest_o,
    output logic                     overflow_o,
    output ex_pkg::word_t            mem_addr_o,
    output ex_pkg::mem_type_t        mem_type_o,
    output ex_pkg::mem_size_t        mem_size_o,
    output logic                     mem_signed_o
);

    ex_pkg::word_t     merged;
    ex_pkg::word_t     result_d;
    ex_pkg::reg_addr_t dest_d;

    // units drive zero outside their own instructions
    assign merged = alu_result_i | shift_result_i | count_result_i;

    always_comb
    begin
        result_d = merged;
        dest_d   = '0;
        case (opd.inst)
            ex_pkg::INST_ADD, ex_pkg::INST_ADDU, ex_pkg::INST_SUB, ex_pkg::INST_SUBU,
            ex_pkg::INST_SLT, ex_pkg::INST_SLTU, ex_pkg::INST_AND, ex_pkg::INST_OR,
            ex_pkg::INST_XOR, ex_pkg::INST_NOR, ex_pkg::INST_SLL, ex_pkg::INST_SLLV,
            ex_pkg::INST_SRL, ex_pkg::INST_SRLV, ex_pkg::INST_SRA, ex_pkg::INST_SRAV,
            ex_pkg::INST_CLZ, ex_pkg::INST_CLO:
                dest_d = rd_i;
            ex_pkg::INST_ADDI, ex_pkg::INST_ADDIU, ex_pkg::INST_SLTI, ex_pkg::INST_SLTIU,
            ex_pkg::INST_ANDI, ex_pkg::INST_ORI, ex_pkg::INST_XORI, ex_pkg::INST_LUI:
                dest_d = rt_i;
            ex_pkg::INST_LB, ex_pkg::INST_LBU, ex_pkg::INST_LH, ex_pkg::INST_LHU,
            ex_pkg::INST_LW:
            begin
                result_d = opd.rt_val;
                dest_d   = rt_i;
            end
            // store data travels on the result bus, no write-back
            ex_pkg::INST_SB, ex_pkg::INST_SH, ex_pkg::INST_SW:
                result_d = opd.rt_val;
            ex_pkg::INST_MOVZ:
            begin
                result_d = opd.rs_val;
                dest_d   = (opd.rt_val == '0) ? rd_i : '0;
            end
            ex_pkg::INST_MOVN:
            begin
                result_d = opd.rs_val;
                dest_d   = (opd.rt_val != '0) ? rd_i : '0;
            end
            default:
                result_d = '0;
        endcase

        // trapping overflow cancels the write-back
        if (alu_ovf_i)
        begin
            result_d = '0;
            dest_d   = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_o      <= 1'b0;
            result_o     <= '0;
            dest_o       <= '0;
            overflow_o   <= 1'b0;
            mem_addr_o   <= '0;
            mem_type_o   <= ex_pkg::MEM_TYPE_R2R;
            mem_size_o   <= ex_pkg::MEM_SIZE_WORD;
            mem_signed_o <= 1'b1;
        end
        else
        begin
            valid_o <= valid_i;
            // outputs hold between strobes
            if (valid_i)
            begin
                result_o     <= result_d;
                dest_o       <= dest_d;
                overflow_o   <= alu_ovf_i;
                mem_addr_o   <= mem_addr_i;
                mem_type_o   <= mem_type_i;
                mem_size_o   <= mem_size_i;
                mem_signed_o <= mem_signed_i;
            end
        end
    end

endmodule

//--- ex_top.sv
// execute stage top level: operand bundle, computing units and the output register
`timescale 1ns/1ps

module ex_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  ex_pkg::inst_code_t inst_i,
    input  ex_pkg::word_t     rs_val_i,
    input  ex_pkg::word_t     rt_val_i,
    input  ex_pkg::reg_addr_t rt_i,
    input  ex_pkg::reg_addr_t rd_i,
    input  ex_pkg::imm_t      imm_i,
    input  ex_pkg::shamt_t    shamt_i,
    output logic              valid_o,
    output ex_pkg::word_t     result_o,
    output ex_pkg::reg_addr_t dest_o,
    output logic              overflow_o,
    output ex_pkg::word_t     mem_addr_o,
    output ex_pkg::mem_type_t mem_type_o,
    output ex_pkg::mem_size_t mem_size_o,
    output logic              mem_signed_o
);

    ex_pkg::word_t     alu_result;
    logic              alu_ovf;
    ex_pkg::word_t     shift_result;
    ex_pkg::word_t     count_result;
    ex_pkg::word_t     mem_addr;
    ex_pkg::mem_type_t mem_type;
    ex_pkg::mem_size_t mem_size;
    logic              mem_signed;

    ex_operand_if opd_if ();

    // fill the operand bundle from the ports
    assign opd_if.inst   = inst_i;
    assign opd_if.rs_val = rs_val_i;
    assign opd_if.rt_val = rt_val_i;
    assign opd_if.imm    = imm_i;
    assign opd_if.shamt  = shamt_i;

    ex_alu alu0 (
        .opd          (opd_if.unit),
        .alu_result_o (alu_result),
        .alu_ovf_o    (alu_ovf)
    );

    ex_shifter shifter0 (
        .opd            (opd_if.unit),
        .shift_result_o (shift_result)
    );

    ex_lead_count lead_count0 (
        .opd            (opd_if.unit),
        .count_result_o (count_result)
    );

    ex_mem_ctrl mem_ctrl0 (
        .opd          (opd_if.unit),
        .mem_addr_o   (mem_addr),
        .mem_type_o   (mem_type),
        .mem_size_o   (mem_size),
        .mem_signed_o (mem_signed)
    );

    ex_result_stage result_stage0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .opd            (opd_if.unit),
        .rt_i           (rt_i),
        .rd_i           (rd_i),
        .alu_result_i   (alu_result),
        .alu_ovf_i      (alu_ovf),
        .shift_result_i (shift_result),
        .count_result_i (count_result),
        .mem_addr_i     (mem_addr),
        .mem_type_i     (mem_type),
        .mem_size_i     (mem_size),
        .mem_signed_i   (mem_signed),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .dest_o         (dest_o),
        .overflow_o     (overflow_o),
        .mem_addr_o     (mem_addr_o),
        .mem_type_o     (mem_type_o),
        .mem_size_o     (mem_size_o),
        .mem_signed_o   (mem_signed_o)
    );

endmodule

//--- tb_ex_top.sv
// testbench for the execute stage: table-driven rows with a reference model and a watchdog
`timescale 1ns/1ps

module tb_ex_top;

    localparam int                NUM_RAND = 16;
    localparam ex_pkg::reg_addr_t RT_A     = 5'd7;
    localparam ex_pkg::reg_addr_t RD_A     = 5'd9;

    typedef struct packed {
        ex_pkg::inst_code_t inst;
        ex_pkg::word_t      rs;
        ex_pkg::word_t      rt;
        ex_pkg::reg_addr_t  rt_a;
        ex_pkg::reg_addr_t  rd_a;
        ex_pkg::imm_t       imm;
        ex_pkg::shamt_t     shamt;
        logic               gap;
        ex_pkg::word_t      res;
        ex_pkg::reg_addr_t  dest;
        logic               ovf;
        ex_pkg::word_t      addr;
        ex_pkg::mem_type_t  mtype;
        ex_pkg::mem_size_t  msize;
        logic               msigned;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               valid_i;
    ex_pkg::inst_code_t inst_i;
    ex_pkg::word_t      rs_val_i;
    ex_pkg::word_t      rt_val_i;
    ex_pkg::reg_addr_t  rt_i;
    ex_pkg::reg_addr_t  rd_i;
    ex_pkg::imm_t       imm_i;
    ex_pkg::shamt_t     shamt_i;
    logic               valid_o;
    ex_pkg::word_t      result_o;
    ex_pkg::reg_addr_t  dest_o;
    logic               overflow_o;
    ex_pkg::word_t      mem_addr_o;
    ex_pkg::mem_type_t  mem_type_o;
    ex_pkg::mem_size_t  mem_size_o;
    logic               mem_signed_o;

    row_t table_q[$];
    logic pending_gap;
    logic table_ready;

    ex_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .inst_i       (inst_i),
        .rs_val_i     (rs_val_i),
        .rt_val_i     (rt_val_i),
        .rt_i         (rt_i),
        .rd_i         (rd_i),
        .imm_i        (imm_i),
        .shamt_i      (shamt_i),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .dest_o       (dest_o),
        .overflow_o   (overflow_o),
        .mem_addr_o   (mem_addr_o),
        .mem_type_o   (mem_type_o),
        .mem_size_o   (mem_size_o),
        .mem_signed_o (mem_signed_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input ex_pkg::word_t got,
                              input ex_pkg::word_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_reg(input string name, input ex_pkg::reg_addr_t got,
                             input ex_pkg::reg_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_mem_type(input string name, input ex_pkg::mem_type_t got,
                                  input ex_pkg::mem_type_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_mem_size(input string name, input ex_pkg::mem_size_t got,
                                  input ex_pkg::mem_size_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // non-memory row, memory outputs at their idle values
    task automatic add_row(input ex_pkg::inst_code_t inst, input ex_pkg::word_t rs,
                           input ex_pkg::word_t rt, input ex_pkg::imm_t imm,
                           input ex_pkg::shamt_t shamt, input ex_pkg::word_t res,
                           input ex_pkg::reg_addr_t dest, input logic ovf);
        row_t r;
        r = '{inst, rs, rt, RT_A, RD_A, imm, shamt, pending_gap, res, dest, ovf,
              32'h0, ex_pkg::MEM_TYPE_R2R, ex_pkg::MEM_SIZE_WORD, 1'b1};
        pending_gap = 1'b0;
        table_q.push_back(r);
    endtask

    // load or store row, result carries rt_val
    task automatic add_mem(input ex_pkg::inst_code_t inst, input ex_pkg::word_t rs,
                           input ex_pkg::word_t rt, input ex_pkg::imm_t imm,
                           input ex_pkg::word_t addr, input ex_pkg::mem_type_t mtype,
                           input ex_pkg::mem_size_t msize, input logic msigned,
                           input ex_pkg::reg_addr_t dest);
        row_t r;
        r = '{inst, rs, rt, RT_A, RD_A, imm, 5'd0, pending_gap, rt, dest, 1'b0,
              addr, mtype, msize, msigned};
        pending_gap = 1'b0;
        table_q.push_back(r);
    endtask

    // reference for the register-form ALU ops used by the random rows
    function automatic row_t model_row(input ex_pkg::inst_code_t inst, input ex_pkg::word_t rs,
                                       input ex_pkg::word_t rt, input ex_pkg::reg_addr_t rt_a,
                                       input ex_pkg::reg_addr_t rd_a);
        row_t   r;
        longint wide;
        r = '{inst, rs, rt, rt_a, rd_a, 16'h0, 5'd0, 1'b0, 32'h0, rd_a, 1'b0,
              32'h0, ex_pkg::MEM_TYPE_R2R, ex_pkg::MEM_SIZE_WORD, 1'b1};
        wide = 0;
        case (inst)
            ex_pkg::INST_ADD:
                wide = longint'($signed(rs)) + longint'($signed(rt));
            ex_pkg::INST_SUB:
                wide = longint'($signed(rs)) - longint'($signed(rt));
            default:
                wide = 0;
        endcase
        r.ovf = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
        case (inst)
            ex_pkg::INST_ADD, ex_pkg::INST_ADDU: r.res = rs + rt;
            ex_pkg::INST_SUB, ex_pkg::INST_SUBU: r.res = rs - rt;
            ex_pkg::INST_AND:  r.res = rs & rt;
            ex_pkg::INST_OR:   r.res = rs | rt;
            ex_pkg::INST_XOR:  r.res = rs ^ rt;
            ex_pkg::INST_SLT:  r.res = ($signed(rs) < $signed(rt)) ? 32'h1 : 32'h0;
            ex_pkg::INST_SLTU: r.res = (rs < rt) ? 32'h1 : 32'h0;
            default:           r.res = 32'h0;
        endcase
        // trapping overflow drops the write-back
        if (r.ovf)
        begin
            r.res  = 32'h0;
            r.dest = 5'd0;
        end
        return r;
    endfunction

    task automatic build_table();
        ex_pkg::inst_code_t rand_ops [9];
        row_t               r;
        rand_ops = '{ex_pkg::INST_ADD, ex_pkg::INST_ADDU, ex_pkg::INST_SUB, ex_pkg::INST_SUBU,
                     ex_pkg::INST_AND, ex_pkg::INST_OR, ex_pkg::INST_XOR, ex_pkg::INST_SLT,
                     ex_pkg::INST_SLTU};
        add_row(ex_pkg::INST_ADD, 32'h7fffffff, 32'h1, 16'h0, 5'd0, 32'h0, 5'd0, 1'b1);
        add_row(ex_pkg::INST_ADD, 32'h5, 32'h3, 16'h0, 5'd0, 32'h8, RD_A, 1'b0);
        add_row(ex_pkg::INST_SUB, 32'h80000000, 32'h1, 16'h0, 5'd0, 32'h0, 5'd0, 1'b1);
        add_row(ex_pkg::INST_SUB, 32'ha, 32'h3, 16'h0, 5'd0, 32'h7, RD_A, 1'b0);
        add_row(ex_pkg::INST_ADDU, 32'h7fffffff, 32'h1, 16'h0, 5'd0, 32'h80000000, RD_A, 1'b0);
        add_row(ex_pkg::INST_ADDI, 32'h7ffffff0, 32'h0, 16'h0010, 5'd0, 32'h0, 5'd0, 1'b1);
        add_row(ex_pkg::INST_ADDIU, 32'h10, 32'h0, 16'hfff0, 5'd0, 32'h0, RT_A, 1'b0);
        // operands differing only in sign
        add_row(ex_pkg::INST_SLT, 32'hffffffff, 32'h1, 16'h0, 5'd0, 32'h1, RD_A, 1'b0);
        add_row(ex_pkg::INST_SLTU, 32'hffffffff, 32'h1, 16'h0, 5'd0, 32'h0, RD_A, 1'b0);
        add_row(ex_pkg::INST_SLTI, 32'hffffffff, 32'h0, 16'h0001, 5'd0, 32'h1, RT_A, 1'b0);
        // sign-extended immediate, compared unsigned
        add_row(ex_pkg::INST_SLTIU, 32'h00010000, 32'h0, 16'hffff, 5'd0, 32'h1, RT_A, 1'b0);
        add_row(ex_pkg::INST_ANDI, 32'hffffffff, 32'h0, 16'h8001, 5'd0, 32'h8001, RT_A, 1'b0);
        add_row(ex_pkg::INST_ORI, 32'h12340000, 32'h0, 16'hffff, 5'd0, 32'h1234ffff, RT_A, 1'b0);
        add_row(ex_pkg::INST_XORI, 32'hffff0000, 32'h0, 16'h8000, 5'd0, 32'hffff8000, RT_A, 1'b0);
        add_row(ex_pkg::INST_LUI, 32'h0, 32'h0, 16'habcd, 5'd0, 32'habcd0000, RT_A, 1'b0);
        add_row(ex_pkg::INST_NOR, 32'hf0f0f0f0, 32'h0f0f0000, 16'h0, 5'd0, 32'h0f0f, RD_A, 1'b0);
        // shifts
        add_row(ex_pkg::INST_SLL, 32'h0, 32'h1, 16'h0, 5'd31, 32'h80000000, RD_A, 1'b0);
        add_row(ex_pkg::INST_SRA, 32'h0, 32'h80000000, 16'h0, 5'd4, 32'hf8000000, RD_A, 1'b0);
        add_row(ex_pkg::INST_SRAV, 32'h24, 32'hf0000000, 16'h0, 5'd0, 32'hff000000, RD_A, 1'b0);
        add_row(ex_pkg::INST_SRLV, 32'h3f, 32'h80000000, 16'h0, 5'd0, 32'h1, RD_A, 1'b0);
        add_row(ex_pkg::INST_SRL, 32'h0, 32'hf0000000, 16'h0, 5'd28, 32'hf, RD_A, 1'b0);
        // leading counts
        add_row(ex_pkg::INST_CLZ, 32'h0, 32'h0, 16'h0, 5'd0, 32'd32, RD_A, 1'b0);
        add_row(ex_pkg::INST_CLO, 32'hffffffff, 32'h0, 16'h0, 5'd0, 32'd32, RD_A, 1'b0);
        add_row(ex_pkg::INST_CLZ, 32'h00010000, 32'h0, 16'h0, 5'd0, 32'd15, RD_A, 1'b0);
        add_row(ex_pkg::INST_CLO, 32'hfff00000, 32'h0, 16'h0, 5'd0, 32'd12, RD_A, 1'b0);
        // conditional moves, with a missing strobe in front
        pending_gap = 1'b1;
        add_row(ex_pkg::INST_MOVZ, 32'hdeadbeef, 32'h0, 16'h0, 5'd0, 32'hdeadbeef, RD_A, 1'b0);
        add_row(ex_pkg::INST_MOVZ, 32'hdeadbeef, 32'h5, 16'h0, 5'd0, 32'hdeadbeef, 5'd0, 1'b0);
        add_row(ex_pkg::INST_MOVN, 32'h12345678, 32'h5, 16'h0, 5'd0, 32'h12345678, RD_A, 1'b0);
        add_row(ex_pkg::INST_MOVN, 32'h12345678, 32'h0, 16'h0, 5'd0, 32'h12345678, 5'd0, 1'b0);
        // loads and stores, negative offsets
        add_mem(ex_pkg::INST_LB, 32'h1000, 32'h55, 16'hfffc, 32'h0ffc,
                ex_pkg::MEM_TYPE_M2R, ex_pkg::MEM_SIZE_BYTE, 1'b1, RT_A);
        add_mem(ex_pkg::INST_LBU, 32'h10, 32'h66, 16'hfffc, 32'hc,
                ex_pkg::MEM_TYPE_M2R, ex_pkg::MEM_SIZE_BYTE, 1'b0, RT_A);
        add_mem(ex_pkg::INST_LHU, 32'h2000, 32'h77, 16'hfffe, 32'h1ffe,
                ex_pkg::MEM_TYPE_M2R, ex_pkg::MEM_SIZE_HALF, 1'b0, RT_A);
        add_mem(ex_pkg::INST_LW, 32'h100, 32'h88, 16'hfff0, 32'hf0,
                ex_pkg::MEM_TYPE_M2R, ex_pkg::MEM_SIZE_WORD, 1'b1, RT_A);
        add_mem(ex_pkg::INST_SB, 32'h3000, 32'haa, 16'hffff, 32'h2fff,
                ex_pkg::MEM_TYPE_R2M, ex_pkg::MEM_SIZE_BYTE, 1'b1, 5'd0);
        add_mem(ex_pkg::INST_SH, 32'h40, 32'hbb, 16'hfff8, 32'h38,
                ex_pkg::MEM_TYPE_R2M, ex_pkg::MEM_SIZE_HALF, 1'b1, 5'd0);
        for (int k = 0; k < NUM_RAND; k++)
        begin
            r = model_row(rand_ops[$urandom % 9], $urandom, $urandom,
                          ex_pkg::reg_addr_t'(1 + ($urandom % 31)),
                          ex_pkg::reg_addr_t'(1 + ($urandom % 31)));
            r.gap = (($urandom % 4) == 0);
            table_q.push_back(r);
        end
    endtask

    task automatic drive_row(input row_t r);
        valid_i  = 1'b1;
        inst_i   = r.inst;
        rs_val_i = r.rs;
        rt_val_i = r.rt;
        rt_i     = r.rt_a;
        rd_i     = r.rd_a;
        imm_i    = r.imm;
        shamt_i  = r.shamt;
    endtask

    task automatic check_outputs(input row_t r);
        check_bit("valid_o", valid_o, 1'b1);
        check_word("result_o", result_o, r.res);
        check_reg("dest_o", dest_o, r.dest);
        check_bit("overflow_o", overflow_o, r.ovf);
        check_word("mem_addr_o", mem_addr_o, r.addr);
        check_mem_type("mem_type_o", mem_type_o, r.mtype);
        check_mem_size("mem_size_o", mem_size_o, r.msize);
        check_bit("mem_signed_o", mem_signed_o, r.msigned);
    endtask

    // each row takes at most two cycles
    initial
    begin
        int limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = (table_q.size() * 2 + 10 + 20) * 20;
        #(limit_ns);
        abort_run("timeout: the run did not reach its end in time");
    end

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        valid_i     = 1'b0;
        inst_i      = ex_pkg::INST_NOP;
        rs_val_i    = '0;
        rt_val_i    = '0;
        rt_i        = '0;
        rd_i        = '0;
        imm_i       = '0;
        shamt_i     = '0;
        pending_gap = 1'b0;
        table_ready = 1'b0;
        void'($urandom(11589));
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // reset values before any strobe
        check_bit("valid_o", valid_o, 1'b0);
        check_word("result_o", result_o, 32'h0);
        check_reg("dest_o", dest_o, 5'd0);
        check_bit("overflow_o", overflow_o, 1'b0);
        check_mem_type("mem_type_o", mem_type_o, ex_pkg::MEM_TYPE_R2R);
        check_mem_size("mem_size_o", mem_size_o, ex_pkg::MEM_SIZE_WORD);
        check_bit("mem_signed_o", mem_signed_o, 1'b1);

        for (int i = 0; i < table_q.size(); i++)
        begin
            drive_row(table_q[i]);
            @(posedge clk);
            #1;
            check_outputs(table_q[i]);
            if ((i + 1 < table_q.size()) && table_q[i + 1].gap)
            begin
                // no strobe this cycle, new inputs must not reach the outputs
                valid_i = 1'b0;
                inst_i  = ex_pkg::INST_LUI;
                imm_i   = ~table_q[i].res[31:16];
                rt_i    = ~table_q[i].dest;
                @(posedge clk);
                #1;
                check_bit("valid_o", valid_o, 1'b0);
                check_word("result_o", result_o, table_q[i].res);
                check_reg("dest_o", dest_o, table_q[i].dest);
            end
        end
        valid_i = 1'b0;
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- src.f
ex_pkg.sv
ex_operand_if.sv
ex_alu.sv
ex_shifter.sv
ex_lead_count.sv
ex_mem_ctrl.sv
ex_result_stage.sv
ex_top.sv
tb_ex_top.sv
